/* hdl/cfg_table.svh */
// sensor register table

localparam cam_cfg_pkg::cfg_entry_t CFG_TABLE [cam_cfg_pkg::CFG_NUM] = '{
    // reg_addr  reg_val
    '{16'h3103, 8'h11},  // clock from pad
    '{16'h3008, 8'h82},  // software reset
    '{16'h3008, 8'h42},  // power down during setup
    '{16'h3103, 8'h03},  // system clock from pll
    '{16'h3017, 8'hff},  // output drive
    '{16'h3018, 8'hff},
    // pll
    '{16'h3034, 8'h1a},
    '{16'h3035, 8'h41},
    '{16'h3036, 8'h69},
    '{16'h3037, 8'h13},  // root and pre divider
    '{16'h4300, 8'h61},  // format control
    '{16'h501f, 8'h01},
    // output size 1024 x 720
    '{16'h3808, 8'h04},
    '{16'h3809, 8'h00},
    '{16'h380a, 8'h02},
    '{16'h380b, 8'hd0}
};

/* hdl/cam_cfg_pkg.sv */
// camera config engine
// shared constants and types
package cam_cfg_pkg;

    // ------------------------------------------------------------------------
    // bus and table constants
    // ------------------------------------------------------------------------
    localparam logic [7:0] SCCB_DEV_ID   = 8'h78;  // sensor write address
    localparam int         CFG_NUM       = 16;
    localparam int         CFG_IDX_W     = 4;
    localparam int         QUARTER_DIV   = 125;    // 100 kHz bus at 50 MHz
    localparam int         QUARTER_W     = $clog2(QUARTER_DIV);
    localparam int         SYM_PER_WRITE = 38;     // start, 4 x 9 bits, stop

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [15:0] reg_addr;
        logic [7:0]  reg_val;
    } cfg_entry_t;

    typedef enum logic [1:0] {
        sym_start,
        sym_bit,
        sym_release,
        sym_stop
    } sym_kind_t;

    // one bus symbol
    typedef struct packed {
        sym_kind_t kind;
        logic      bit_val;
    } sccb_cmd_t;

endpackage

/* hdl/cfg_sequencer.sv */
// register table sequencer
`timescale 1ns/1ns

module cfg_sequencer (
    input  logic                    sysclk,
    input  logic                    rst_n,
    output logic                    start,
    output cam_cfg_pkg::cfg_entry_t entry,
    input  logic                    busy,
    input  logic                    done,
    output logic                    cfg_done
);
    import cam_cfg_pkg::*;

    `include "cfg_table.svh"

    typedef enum logic [1:0] {
        ST_LAUNCH,
        ST_WAIT,
        ST_FINISHED
    } seq_state_t;

    seq_state_t           state;
    logic [CFG_IDX_W-1:0] idx;
    logic                 armed;       // one settling cycle out of reset
    logic                 last_entry;

    assign last_entry = (idx == CFG_IDX_W'(CFG_NUM - 1));
    assign entry      = CFG_TABLE[idx];

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_LAUNCH;
            idx      <= '0;
            armed    <= 1'b0;
            start    <= 1'b0;
            cfg_done <= 1'b0;
        end else begin
            armed <= 1'b1;
            start <= 1'b0;
            case (state)
                ST_LAUNCH: begin
                    if (armed && !busy) begin
                        start <= 1'b1;
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (done) begin
                        if (last_entry) begin
                            cfg_done <= 1'b1;
                            state    <= ST_FINISHED;
                        end else begin
                            idx   <= idx + 1'b1;  // next row launches right away
                            start <= 1'b1;
                        end
                    end
                end
                ST_FINISHED: cfg_done <= 1'b1;  // park until reset
                default:     state <= ST_LAUNCH;
            endcase
        end
    end

    // index never wraps past the last row
    a_idx_park: assert property (@(posedge sysclk) disable iff (!rst_n)
        last_entry |=> last_entry);

endmodule

/* hdl/sccb_frame.sv */
// sccb write framer
`timescale 1ns/1ns

module sccb_frame (
    input  logic                    sysclk,
    input  logic                    rst_n,
    input  logic                    start,
    input  cam_cfg_pkg::cfg_entry_t entry,
    output logic                    busy,
    output logic                    done,
    output cam_cfg_pkg::sccb_cmd_t  cmd,
    output logic                    cmd_strobe,
    input  logic                    sym_done
);
    import cam_cfg_pkg::*;

    logic [31:0] shreg;      // id, addr hi, addr lo, value
    logic [1:0]  byte_cnt;
    logic [3:0]  bit_cnt;    // bits sent in current byte
    logic        adv;
    logic        issue_bit;

    assign adv = busy && sym_done;

    // next symbol is a data bit
    always_comb begin
        case (cmd.kind)
            sym_start:   issue_bit = adv;
            sym_bit:     issue_bit = adv && (bit_cnt != 4'd8);
            sym_release: issue_bit = adv && (byte_cnt != 2'd3);
            default:     issue_bit = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // symbol sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            cmd_strobe <= 1'b0;
            cmd        <= '{kind: sym_stop, bit_val: 1'b0};
            byte_cnt   <= '0;
            bit_cnt    <= '0;
        end else begin
            done       <= 1'b0;
            cmd_strobe <= 1'b0;
            if (done) begin
                busy <= 1'b0;
            end
            if (start) begin
                busy       <= 1'b1;
                cmd        <= '{kind: sym_start, bit_val: 1'b0};
                cmd_strobe <= 1'b1;
                byte_cnt   <= '0;
                bit_cnt    <= '0;
            end else if (issue_bit) begin
                cmd        <= '{kind: sym_bit, bit_val: shreg[31]};  // msb first
                cmd_strobe <= 1'b1;
                bit_cnt    <= bit_cnt + 4'd1;
                if (cmd.kind == sym_release) begin
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end else if (adv) begin
                case (cmd.kind)
                    sym_bit: begin
                        cmd        <= '{kind: sym_release, bit_val: 1'b1};  // ninth bit
                        cmd_strobe <= 1'b1;
                        bit_cnt    <= '0;
                    end
                    sym_release: begin
                        cmd        <= '{kind: sym_stop, bit_val: 1'b0};
                        cmd_strobe <= 1'b1;
                    end
                    default: done <= 1'b1;  // stop has gone out
                endcase
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (start) begin
            shreg <= {SCCB_DEV_ID, entry.reg_addr, entry.reg_val};
        end else if (issue_bit) begin
            shreg <= {shreg[30:0], 1'b0};
        end
    end

    a_start_idle: assert property (@(posedge sysclk) disable iff (!rst_n)
        start |-> !busy);

    // strobes only follow a finished symbol or a new write
    a_strobe_src: assert property (@(posedge sysclk) disable iff (!rst_n)
        cmd_strobe |-> $past(sym_done) || $past(start));

endmodule

/* hdl/sccb_phy.sv */
// sccb line driver
`timescale 1ns/1ns

module sccb_phy (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  cam_cfg_pkg::sccb_cmd_t cmd,
    input  logic                   cmd_strobe,
    output logic                   sym_done,
    output logic                   cmos_sclk,
    inout  wire                    cmos_sdat
);
    import cam_cfg_pkg::*;

    logic [QUARTER_W-1:0] div;
    logic [1:0]           phase;
    logic                 active;
    logic                 sda_oe;      // 1 pulls data low
    logic                 quarter_end;
    logic [1:0]           lvl_first;   // {sclk, sda_oe}
    logic [1:0]           lvl_next;
    sccb_cmd_t            cmd_q;

    // line levels held during one quarter of a symbol
    function automatic logic [1:0] quarter_lvl(sccb_cmd_t c, logic [1:0] ph);
        logic clk_hi;
        logic drive;
        clk_hi = (ph == 2'd1) || (ph == 2'd2);
        drive  = 1'b0;
        case (c.kind)
            sym_start: begin
                clk_hi = !ph[1];          // data falls, then clock
                drive  = 1'b1;
            end
            sym_stop: begin
                clk_hi = (ph != 2'd0);
                drive  = (ph != 2'd3);    // release with clock high
            end
            sym_bit:  drive = !c.bit_val;
            default:  drive = 1'b0;       // ninth bit leaves the line released
        endcase
        return {clk_hi, drive};
    endfunction

    assign quarter_end = (div == QUARTER_W'(QUARTER_DIV - 1));
    assign sym_done    = active && quarter_end && (phase == 2'd3);
    assign lvl_first   = quarter_lvl(cmd, 2'd0);
    assign lvl_next    = quarter_lvl(cmd_q, phase + 2'd1);

    // ------------------------------------------------------------------------
    // quarter timing
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            div       <= '0;
            phase     <= '0;
            cmos_sclk <= 1'b1;
            sda_oe    <= 1'b0;
        end else if (cmd_strobe) begin
            active              <= 1'b1;
            div                 <= '0;
            phase               <= '0;
            {cmos_sclk, sda_oe} <= lvl_first;
        end else if (active) begin
            if (quarter_end) begin
                div   <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd3) begin
                    active <= 1'b0;              // lines hold until next strobe
                end else begin
                    {cmos_sclk, sda_oe} <= lvl_next;
                end
            end else begin
                div <= div + 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (cmd_strobe) begin
            cmd_q <= cmd;
        end
    end

    assign cmos_sdat = sda_oe ? 1'b0 : 1'bz;  // open drain

    // data bits move only while the clock is low on both sides
    a_data_clk_low: assert property (@(posedge sysclk) disable iff (!rst_n)
        $changed(sda_oe) && (cmd_q.kind inside {sym_bit, sym_release})
        |-> !$past(cmos_sclk) && !cmos_sclk);

endmodule

/* hdl/cam_cfg_top.sv */
// camera sensor config engine
`timescale 1ns/1ns

module cam_cfg_top (
    input  logic sysclk,
    input  logic rst_n,
    output logic cmos_sclk,
    inout  wire  cmos_sdat,
    output logic cfg_done
);
    import cam_cfg_pkg::*;

    logic       start;
    logic       busy;
    logic       done;
    logic       cmd_strobe;
    logic       sym_done;
    cfg_entry_t entry;
    sccb_cmd_t  cmd;

    cfg_sequencer u_seq (
        .sysclk   (sysclk),
        .rst_n    (rst_n),
        .start    (start),
        .entry    (entry),
        .busy     (busy),
        .done     (done),
        .cfg_done (cfg_done)
    );

    sccb_frame u_frame (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .start      (start),
        .entry      (entry),
        .busy       (busy),
        .done       (done),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .sym_done   (sym_done)
    );

    sccb_phy u_phy (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .sym_done   (sym_done),
        .cmos_sclk  (cmos_sclk),
        .cmos_sdat  (cmos_sdat)
    );

endmodule

/* bench/sccb_monitor.sv */
// sccb bus model and checker
`timescale 1ns/1ns

module sccb_monitor (
    input  logic sysclk,
    input  logic rst_n,
    input  logic cmos_sclk,
    inout  wire  cmos_sdat,
    input  logic cfg_done,
    output int   writes,
    output logic in_write,
    output int   errors
);
    import cam_cfg_pkg::*;

    `include "cfg_table.svh"

    logic        prev_sclk;
    logic        prev_sda;
    logic        pre_first;   // no start seen since reset
    logic        sda;
    logic        sclk_rise;
    logic        start_cond;
    logic        stop_cond;
    logic [31:0] data;
    int          bit_cnt;     // clock rises in this write

    pullup (cmos_sdat);

    assign sda        = cmos_sdat;
    assign sclk_rise  = cmos_sclk && !prev_sclk;
    assign start_cond = cmos_sclk && prev_sclk && prev_sda && !sda;
    assign stop_cond  = cmos_sclk && prev_sclk && !prev_sda && sda;

    // id byte, address high, address low, value
    function automatic logic [31:0] expected_word(int k);
        cfg_entry_t row;
        row = CFG_TABLE[k % CFG_NUM];
        return {8'h78, row.reg_addr[15:8], row.reg_addr[7:0], row.reg_val};
    endfunction

    initial errors = 0;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            prev_sclk <= 1'b1;
            prev_sda  <= 1'b1;
            pre_first <= 1'b1;
            in_write  <= 1'b0;
            writes    <= 0;
            bit_cnt   <= 0;
            data      <= '0;
        end else begin
            prev_sclk <= cmos_sclk;
            prev_sda  <= sda;
            if (start_cond) begin
                pre_first <= 1'b0;
                in_write  <= 1'b1;
                bit_cnt   <= 0;
            end else if (stop_cond) begin
                in_write <= 1'b0;
                writes   <= writes + 1;
            end else if (sclk_rise && in_write) begin
                bit_cnt <= bit_cnt + 1;
                if (bit_cnt < 36 && bit_cnt % 9 != 8) begin
                    data <= {data[30:0], sda};  // msb first
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // bus checks
    // ------------------------------------------------------------------------
    a_idle: assert property (@(posedge sysclk)
        pre_first && !start_cond |-> cmos_sclk && sda && !cfg_done)
        else begin
            $display("mismatch at %0t ns: bus or cfg_done not idle before first write", $time);
            errors++;
        end

    // 36 bit clocks plus the clock of the stop
    a_legal: assert property (@(posedge sysclk) disable iff (!rst_n)
        sda != prev_sda |-> (!cmos_sclk && !prev_sclk) || (start_cond && !in_write)
            || (stop_cond && in_write && bit_cnt == 37))
        else begin
            $display("bus error at %0t ns: data moved while the clock was high", $time);
            errors++;
        end

    a_write: assert property (@(posedge sysclk) disable iff (!rst_n)
        stop_cond |-> writes < CFG_NUM && data == expected_word(writes))
        else begin
            $display("mismatch at %0t ns: write %0d sent %h, table gives %h", $time,
                $sampled(writes), $sampled(data), expected_word($sampled(writes)));
            errors++;
        end

    a_ninth: assert property (@(posedge sysclk) disable iff (!rst_n)
        sclk_rise && in_write && bit_cnt % 9 == 8 |-> sda)
        else begin
            $display("mismatch at %0t ns: ninth bit driven low", $time);
            errors++;
        end

endmodule

/* bench/tb_cam_cfg.sv */
// camera config engine bench
`timescale 1ns/1ns

module tb_cam_cfg;
    import cam_cfg_pkg::*;

    localparam int RST_CYC    = 3;
    localparam int QUIET_CYC  = 8 * QUARTER_DIV;   // two bus bits
    localparam int OFFSET_MIN = 1000;
    localparam int OFFSET_W   = 18;                // stays inside one table walk
    localparam int SEQ_NS     = CFG_NUM * SYM_PER_WRITE * 4 * QUARTER_DIV * 10;
    localparam int RESTART_NS = SEQ_NS + (OFFSET_MIN + (1 << OFFSET_W) + 2 * RST_CYC) * 10;
    localparam int LIMIT_NS   = 2 * SEQ_NS + RESTART_NS;

    logic        sysclk;
    logic        rst_n;
    logic        cmos_sclk;
    logic        cfg_done;
    wire         cmos_sdat;
    int          mon_writes;
    logic        mon_in_write;
    int          mon_errors;
    int          fail_cnt;
    int          test_cnt;
    int          bad_tests;
    int          base_errs;
    int          offset;
    logic [31:0] lfsr;

    cam_cfg_top DUT (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .cmos_sclk (cmos_sclk),
        .cmos_sdat (cmos_sdat),
        .cfg_done  (cfg_done)
    );

    sccb_monitor u_mon (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .cmos_sclk (cmos_sclk),
        .cmos_sdat (cmos_sdat),
        .cfg_done  (cfg_done),
        .writes    (mon_writes),
        .in_write  (mon_in_write),
        .errors    (mon_errors)
    );

    always #5 sysclk = ~sysclk;

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic int take_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic apply_reset();
        @(posedge sysclk);
        #1 rst_n = 1'b0;
        repeat (RST_CYC) @(posedge sysclk);
        #1 rst_n = 1'b1;
    endtask

    task automatic end_test(string name);
        int n;
        n = fail_cnt + mon_errors - base_errs;
        test_cnt++;
        if (n != 0) begin
            bad_tests++;
        end
        $display("test %-12s %s, %0d errors, %0t ns", name, (n == 0) ? "ok" : "FAILED", n, $time);
        base_errs = fail_cnt + mon_errors;
    endtask

    // ------------------------------------------------------------------------
    // completion checks
    // ------------------------------------------------------------------------
    a_done_count: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(cfg_done) |-> mon_writes == CFG_NUM && !mon_in_write)
        else begin
            $display("mismatch at %0t ns: cfg_done rose after %0d writes", $time,
                $sampled(mon_writes));
            fail_cnt++;
        end

    a_done_quiet: assert property (@(posedge sysclk) disable iff (!rst_n)
        cfg_done |=> cfg_done && $stable(cmos_sclk))
        else begin
            $display("mismatch at %0t ns: cfg_done dropped or sclk moved", $time);
            fail_cnt++;
        end

    initial begin
        #(LIMIT_NS);
        $display("timeout at %0t ns, the configuration never finished", $time);
        $display("tests failed");
        $finish;
    end

    initial begin
        sysclk    = 1'b0;
        rst_n     = 1'b0;
        fail_cnt  = 0;
        test_cnt  = 0;
        bad_tests = 0;
        base_errs = 0;
        lfsr      = 32'h062d_406c;
        repeat (RST_CYC) @(posedge sysclk);
        #1 rst_n = 1'b1;
        wait (mon_in_write);
        end_test("reset_state");
        wait (cfg_done);
        repeat (2) @(posedge sysclk);  // rise check runs one edge later
        end_test("sequence");
        repeat (QUIET_CYC) @(posedge sysclk);
        end_test("quiet");
        // second reset lands mid-walk
        offset = OFFSET_MIN + take_bits(OFFSET_W);
        apply_reset();
        repeat (offset) @(posedge sysclk);
        $display("reset after %0d cycles, %0d writes in", offset, mon_writes);
        apply_reset();
        wait (cfg_done);
        repeat (QUIET_CYC) @(posedge sysclk);
        end_test("restart");
        $display("%0d tests run, %0d failed, %0d check errors", test_cnt, bad_tests,
            fail_cnt + mon_errors);
        if (bad_tests == 0 && fail_cnt + mon_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+hdl
hdl/cam_cfg_pkg.sv
hdl/cfg_sequencer.sv
hdl/sccb_frame.sv
hdl/sccb_phy.sv
hdl/cam_cfg_top.sv
bench/sccb_monitor.sv
bench/tb_cam_cfg.sv
